// ==== hdl/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

    // cache geometry for the single supported configuration
    localparam int addr_w     = 32;
    localparam int num_sets   = 64;
    localparam int num_ways   = 2;
    localparam int block_w    = 128;
    localparam int set_w      = $clog2(num_sets);
    localparam int offset_w   = $clog2(block_w / 8);
    // tag takes whatever the set and offset leave over
    localparam int tag_w      = addr_w - set_w - offset_w;

    // request FIFO depth and requester's starting credits
    localparam int queue_depth = 2;

    // replacement lfsr reset value
    localparam logic [7:0] lfsr_seed = 8'h5a;

    // byte address split with tag at the msb end
    typedef struct packed {
        logic [tag_w-1:0]    tag;
        logic [set_w-1:0]    set;
        logic [offset_w-1:0] offset;
    } addr_fields_t;

    typedef enum logic [1:0] {
        op_load,
        op_fill,
        op_store
    } cache_op_t;

    // one block seen as fill halves or as byte lanes
    typedef union packed {
        logic [block_w/64-1:0][63:0] dwords;
        logic [block_w/8-1:0][7:0]   bytes;
    } block_t;

    typedef struct packed {
        cache_op_t    op;
        addr_fields_t addr;
        // fill takes all 64 bits and store only the low byte
        logic [63:0]  wdata;
    } cache_req_t;

    typedef struct packed {
        logic   hit;
        // way hit or way allocated on a miss
        logic   way;
        // dirty bit of that way before the access
        logic   dirty;
        // fill miss evicting a dirty line
        logic   victim_dirty;
        block_t data;
    } cache_resp_t;

endpackage

`default_nettype wire

// ==== hdl/req_queue.sv ====
`default_nettype none

module req_queue import cache_pkg::*; (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       req_valid,
    input  wire cache_req_t req,
    input  wire logic       issue_ready,
    output logic            issue_valid,
    output cache_req_t      issue_req,
    output logic            credit_return
);

    // entry payloads with occupancy tracked by count
    cache_req_t entries [queue_depth];

    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       pop;

    // head is valid whenever anything is queued
    assign issue_valid = (count != 2'd0);
    assign issue_req   = entries[rd_ptr];
    assign pop         = issue_valid && issue_ready;

    // one credit back per issued entry
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            entries[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            // pointers wrap naturally at depth 2
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together leave count alone
            if (req_valid && !pop) begin
                count <= count + 2'd1;
            end else if (pop && !req_valid) begin
                count <= count - 2'd1;
            end
        end
    end

    // requester sent without a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> (count != 2'(queue_depth)));

endmodule

`default_nettype wire

// ==== hdl/tag_array.sv ====
`default_nettype none

module tag_array import cache_pkg::*; (
    input  wire logic                clk,
    input  wire logic                arst_n,
    // lookup side
    input  wire logic [set_w-1:0]    rd_set,
    input  wire logic [tag_w-1:0]    lookup_tag,
    // update side driven from stage 2
    input  wire logic                wr_en,
    input  wire logic                wr_way,
    input  wire logic [set_w-1:0]    wr_set,
    input  wire logic [tag_w-1:0]    wr_tag,
    input  wire logic                set_dirty,
    input  wire logic                clear_dirty,
    // lookup result one cycle after rd_set
    output logic [num_ways-1:0]      hit_way,
    output logic [num_ways-1:0]      valid_bits,
    output logic [num_ways-1:0]      dirty_bits
);

    // stored tags per way and set
    logic [tag_w-1:0]    tags [num_ways][num_sets];

    // per-set status with one bit per way
    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];

    // registered lookup
    logic [set_w-1:0]    rd_set_q;
    logic [tag_w-1:0]    lookup_tag_q;

    always_ff @(posedge clk) begin
        rd_set_q     <= rd_set;
        lookup_tag_q <= lookup_tag;
    end

    // tag write on allocation
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tags[wr_way][wr_set] <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else begin
            // newly allocated line becomes valid
            if (wr_en) begin
                valid_q[wr_set][wr_way] <= 1'b1;
            end
            // fresh line starts clean and a store marks it
            if (clear_dirty) begin
                dirty_q[wr_set][wr_way] <= 1'b0;
            end else if (set_dirty) begin
                dirty_q[wr_set][wr_way] <= 1'b1;
            end
        end
    end

    // status of the looked-up set
    assign valid_bits = valid_q[rd_set_q];
    assign dirty_bits = dirty_q[rd_set_q];

    // compare both ways and let only valid ones hit
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = valid_bits[w] && (tags[w][rd_set_q] == lookup_tag_q);
        end
    end

    // allocation only on a miss keeps a tag out of both ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0(hit_way));

endmodule

`default_nettype wire

// ==== hdl/data_array.sv ====
`default_nettype none

module data_array import cache_pkg::*; (
    input  wire logic                   clk,
    input  wire logic                   arst_n,
    input  wire logic [set_w-1:0]       rd_set,
    input  wire logic [set_w-1:0]       wr_set,
    input  wire logic                   wr_way,
    // fill halves
    input  wire logic [block_w/64-1:0]  dword_we,
    // store byte lanes
    input  wire logic [block_w/8-1:0]   byte_we,
    input  wire logic [63:0]            wdata,
    output block_t                      way0_data,
    output block_t                      way1_data
);

    // block storage in plain registers
    block_t mem [num_ways][num_sets];

    // write data copied into every lane
    block_t wblk;

    assign wblk = {(block_w / 64){wdata}};

    always_ff @(posedge clk) begin
        // fills write whole halves
        for (int d = 0; d < block_w / 64; d++) begin
            if (dword_we[d]) begin
                mem[wr_way][wr_set].dwords[d] <= wblk.dwords[d];
            end
        end
        // stores write single byte lanes
        for (int b = 0; b < block_w / 8; b++) begin
            if (byte_we[b]) begin
                mem[wr_way][wr_set].bytes[b] <= wblk.bytes[b];
            end
        end
    end

    // registered read of both ways
    always_ff @(posedge clk) begin
        way0_data <= mem[0][rd_set];
        way1_data <= mem[1][rd_set];
    end

    // top never issues a fill and a store in one cycle
    a_we_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        !((|dword_we) && (|byte_we)));

endmodule

`default_nettype wire

// ==== hdl/victim_select.sv ====
`default_nettype none

module victim_select import cache_pkg::*; (
    input  wire logic                clk,
    input  wire logic                arst_n,
    input  wire logic [num_ways-1:0] valid_bits,
    input  wire logic                alloc_both,
    output logic                     victim_way
);

    logic [7:0] lfsr_q;
    logic [7:0] lfsr_next;

    // fibonacci step with taps 8 6 5 4
    assign lfsr_next = {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};

    // advance only when both ways were full
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr_q <= lfsr_seed;
        end else if (alloc_both) begin
            lfsr_q <= lfsr_next;
        end
    end

    // first invalid way wins over the stepped lfsr
    always_comb begin
        if (!valid_bits[0]) begin
            victim_way = 1'b0;
        end else if (!valid_bits[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = lfsr_next[0];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`default_nettype none

module cache_top import cache_pkg::*; (
    input  wire logic  clk,
    input  wire logic  arst_n,
    input  wire logic  req_valid,
    input  wire cache_req_t req,
    output logic       credit_return,
    output logic       resp_valid,
    output cache_resp_t resp
);

    // queue head
    logic              issue_valid;
    logic              issue_ready;
    cache_req_t        issue_req;
    logic              pop;

    // stage 2 request
    logic              s2_valid;
    cache_req_t        s2_req;
    logic              s2_write;

    // array outputs
    logic [num_ways-1:0] hit_way;
    logic [num_ways-1:0] valid_bits;
    logic [num_ways-1:0] dirty_bits;
    block_t            way0_data;
    block_t            way1_data;
    logic              victim_way;

    // stage 2 decisions
    logic              hit;
    logic              hit_idx;
    logic              wr_way;
    logic              fill_miss;
    logic              alloc_both;
    logic              store_hit;
    logic [block_w/64-1:0] dword_we;
    logic [block_w/8-1:0]  byte_we;
    logic [63:0]       wdata;
    cache_resp_t       resp_d;

    req_queue u_queue (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .issue_ready   (issue_ready),
        .issue_valid   (issue_valid),
        .issue_req     (issue_req),
        .credit_return (credit_return)
    );

    // a read of the set being written now would see old data
    assign s2_write    = s2_valid && (s2_req.op != op_load);
    assign issue_ready = !(s2_write && (issue_req.addr.set == s2_req.addr.set));
    assign pop         = issue_valid && issue_ready;

    // stage 1 reads the arrays with the head address
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s2_valid <= 1'b0;
        end else begin
            s2_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            s2_req <= issue_req;
        end
    end

    tag_array u_tags (
        .clk         (clk),
        .arst_n      (arst_n),
        .rd_set      (issue_req.addr.set),
        .lookup_tag  (issue_req.addr.tag),
        .wr_en       (fill_miss),
        .wr_way      (wr_way),
        .wr_set      (s2_req.addr.set),
        .wr_tag      (s2_req.addr.tag),
        .set_dirty   (store_hit),
        .clear_dirty (fill_miss),
        .hit_way     (hit_way),
        .valid_bits  (valid_bits),
        .dirty_bits  (dirty_bits)
    );

    data_array u_data (
        .clk       (clk),
        .arst_n    (arst_n),
        .rd_set    (issue_req.addr.set),
        .wr_set    (s2_req.addr.set),
        .wr_way    (wr_way),
        .dword_we  (dword_we),
        .byte_we   (byte_we),
        .wdata     (wdata),
        .way0_data (way0_data),
        .way1_data (way1_data)
    );

    victim_select u_victim (
        .clk        (clk),
        .arst_n     (arst_n),
        .valid_bits (valid_bits),
        .alloc_both (alloc_both),
        .victim_way (victim_way)
    );

    // stage 2 compare
    assign hit     = |hit_way;
    assign hit_idx = hit_way[1];
    // hit way or the way a miss would take
    assign wr_way  = hit ? hit_idx : victim_way;

    assign fill_miss  = s2_valid && (s2_req.op == op_fill) && !hit;
    assign alloc_both = fill_miss && (&valid_bits);
    assign store_hit  = s2_valid && (s2_req.op == op_store) && hit;

    // fill writes the half picked by offset bit 3 into the hit or allocated way
    always_comb begin
        dword_we = '0;
        if (s2_valid && (s2_req.op == op_fill)) begin
            dword_we[s2_req.addr.offset[3]] = 1'b1;
        end
    end

    // store hit writes one lane and a store miss nothing
    always_comb begin
        byte_we = '0;
        if (store_hit) begin
            byte_we[s2_req.addr.offset] = 1'b1;
        end
    end

    // store byte spread so any lane picks it up
    assign wdata = (s2_req.op == op_store) ? {8{s2_req.wdata[7:0]}} : s2_req.wdata;

    // response with data from the hit way only
    always_comb begin
        resp_d.hit          = hit;
        resp_d.way          = wr_way;
        resp_d.dirty        = dirty_bits[wr_way];
        resp_d.victim_dirty = fill_miss && valid_bits[victim_way] && dirty_bits[victim_way];
        if (!hit) begin
            resp_d.data = '0;
        end else if (hit_idx) begin
            resp_d.data = way1_data;
        end else begin
            resp_d.data = way0_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s2_valid) begin
            resp <= resp_d;
        end
    end

endmodule

`default_nettype wire

// ==== sim/cache_tb.sv ====
`default_nettype none

module cache_tb import cache_pkg::*; ();

    // test length that sets the timeout
    localparam int directed_reqs = 90;
    localparam int rand_reqs     = 400;
    localparam int cycle_limit   = 40 * (directed_reqs + rand_reqs) + 200;

    // expected response plus the bytes the model actually knows
    typedef struct packed {
        cache_resp_t resp;
        block_t      mask;
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    cache_req_t  req;
    logic        credit_return;
    logic        resp_valid;
    cache_resp_t resp;

    // reference model state
    logic [tag_w-1:0]     m_tag   [num_ways][num_sets];
    logic [num_ways-1:0]  m_valid [num_sets];
    logic [num_ways-1:0]  m_dirty [num_sets];
    block_t               m_data  [num_ways][num_sets];
    // bytes ever written with the rest of a line unknown
    logic [block_w/8-1:0] m_known [num_ways][num_sets];
    logic [7:0]           m_lfsr;

    // stimulus and bookkeeping
    logic [15:0] stim_lfsr;
    expect_t     exp_q [$];
    int          credits;
    logic        credit_seen;
    int          sent = 0;
    int          received = 0;
    int          cycles = 0;
    int          value_errs = 0;
    int          order_errs = 0;
    int          proto_errs = 0;

    cache_top UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .resp_valid    (resp_valid),
        .resp          (resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // hard stop well past the longest legal run
    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d responses received",
                     cycles, received, sent);
            $display("test failed");
            $finish;
        end
    end

    // 16-bit fibonacci with taps 16 14 13 11
    function automatic logic [15:0] stim_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // n fresh bits with one step per bit
    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = stim_step(stim_lfsr);
            v = {v[62:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // replacement lfsr step with the parity of taps 8 6 5 4 as new bit
    function automatic logic [7:0] repl_step(logic [7:0] s);
        return {s[6:0], ^(s & 8'hb8)};
    endfunction

    // sequential cache behavior with the response before the update
    function automatic expect_t model_access(cache_req_t r);
        expect_t          e;
        logic [set_w-1:0] s;
        logic             hit;
        logic             way;
        logic [7:0]       stepped;
        s       = r.addr.set;
        hit     = 1'b0;
        way     = 1'b0;
        stepped = repl_step(m_lfsr);
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[s][w] && (m_tag[w][s] == r.addr.tag)) begin
                hit = 1'b1;
                way = 1'(w);
            end
        end
        // miss takes first invalid way before the lfsr pick
        if (!hit) begin
            if (!m_valid[s][0]) begin
                way = 1'b0;
            end else if (!m_valid[s][1]) begin
                way = 1'b1;
            end else begin
                way = stepped[0];
            end
        end
        e.resp.hit          = hit;
        e.resp.way          = way;
        e.resp.dirty        = m_dirty[s][way];
        e.resp.victim_dirty = 1'b0;
        e.resp.data         = '0;
        e.mask              = '1;
        if (hit) begin
            e.resp.data = m_data[way][s];
            for (int b = 0; b < block_w / 8; b++) begin
                e.mask.bytes[b] = m_known[way][s][b] ? 8'hff : 8'h00;
            end
        end
        case (r.op)
            op_fill: begin
                if (!hit) begin
                    e.resp.victim_dirty = m_valid[s][way] && m_dirty[s][way];
                    // lfsr only moves when both ways were taken
                    if (&m_valid[s]) begin
                        m_lfsr = stepped;
                    end
                    m_tag[way][s]   = r.addr.tag;
                    m_valid[s][way] = 1'b1;
                    m_dirty[s][way] = 1'b0;
                end
                m_data[way][s].dwords[r.addr.offset[3]] = r.wdata;
                m_known[way][s][{r.addr.offset[3], 3'b000} +: 8] = 8'hff;
            end
            op_store: begin
                // store miss touches nothing
                if (hit) begin
                    m_data[way][s].bytes[r.addr.offset] = r.wdata[7:0];
                    m_known[way][s][r.addr.offset]      = 1'b1;
                    m_dirty[s][way]                     = 1'b1;
                end
            end
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic compare_value(string field, logic [block_w-1:0] got,
                                 logic [block_w-1:0] want);
        if (got !== want) begin
            $display("ERROR at %0t: %s mismatch, got %h expected %h",
                     $time, field, got, want);
            value_errs++;
        end
    endtask

    // one falling edge where a credit seen last cycle becomes usable
    task automatic step();
        @(negedge clk);
        if (credit_seen) begin
            credits++;
        end
        credit_seen = credit_return;
        if (credits < 0 || credits > queue_depth) begin
            $display("credit count out of range (%0d) at %0t", credits, $time);
            proto_errs++;
        end
    endtask

    task automatic send(cache_op_t op, logic [tag_w-1:0] tag, logic [set_w-1:0] set,
                        logic [offset_w-1:0] off, logic [63:0] wdata);
        cache_req_t r;
        r.op          = op;
        r.addr.tag    = tag;
        r.addr.set    = set;
        r.addr.offset = off;
        r.wdata       = wdata;
        while (credits == 0) begin
            step();
        end
        req       = r;
        req_valid = 1'b1;
        credits--;
        sent++;
        exp_q.push_back(model_access(r));
        step();
        req_valid = 1'b0;
    endtask

    // in-order responses checked field by field
    always @(negedge clk) begin
        expect_t e;
        if (resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("response at %0t with no request outstanding", $time);
                order_errs++;
            end else begin
                e = exp_q.pop_front();
                received++;
                compare_value("hit", 128'(resp.hit), 128'(e.resp.hit));
                compare_value("way", 128'(resp.way), 128'(e.resp.way));
                compare_value("dirty", 128'(resp.dirty), 128'(e.resp.dirty));
                compare_value("victim_dirty", 128'(resp.victim_dirty),
                              128'(e.resp.victim_dirty));
                // unwritten bytes are don't care
                compare_value("data", resp.data & e.mask, e.resp.data & e.mask);
            end
        end
    end

    initial begin
        cache_op_t           op;
        logic [1:0]          op_sel;
        logic [tag_w-1:0]    tag;
        logic [set_w-1:0]    set;
        logic [offset_w-1:0] off;
        arst_n      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        stim_lfsr   = 16'd57;
        credits     = queue_depth;
        credit_seen = 1'b0;
        m_lfsr      = lfsr_seed;
        for (int s = 0; s < num_sets; s++) begin
            m_valid[s]    = '0;
            m_dirty[s]    = '0;
            m_known[0][s] = '0;
            m_known[1][s] = '0;
        end
        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        // every set empty after reset
        for (int s = 0; s < num_sets; s++) begin
            send(op_load, 22'h0, 6'(s), 4'h0, 64'h0);
        end

        // fill one half and load it back before the other half
        send(op_fill, 22'h00a11, 6'd3, 4'h0, 64'h0123_4567_89ab_cdef);
        send(op_load, 22'h00a11, 6'd3, 4'h4, 64'h0);
        send(op_fill, 22'h00a11, 6'd3, 4'h8, 64'hfedc_ba98_7654_3210);
        send(op_load, 22'h00a11, 6'd3, 4'h0, 64'h0);

        // full line and byte stores with dirty shown on the next access
        send(op_fill, 22'h00a22, 6'd5, 4'h0, 64'h1111_2222_3333_4444);
        send(op_fill, 22'h00a22, 6'd5, 4'h8, 64'h5555_6666_7777_8888);
        send(op_store, 22'h00a22, 6'd5, 4'h1, 64'h55);
        send(op_store, 22'h00a22, 6'd5, 4'hc, 64'haa);
        send(op_store, 22'h00a22, 6'd5, 4'hf, 64'h3c);
        send(op_load, 22'h00a22, 6'd5, 4'h0, 64'h0);
        send(op_load, 22'h00a22, 6'd5, 4'h0, 64'h0);

        // store miss leaves the set as it was
        send(op_store, 22'h00a33, 6'd5, 4'h1, 64'hee);
        send(op_load, 22'h00a33, 6'd5, 4'h1, 64'h0);
        send(op_load, 22'h00a22, 6'd5, 4'h0, 64'h0);

        // more tags than ways so the dirty line gets evicted too
        for (int t = 0; t < 6; t++) begin
            send(op_fill, 22'h00b00 + 22'(t), 6'd5, 4'h0, {16{4'(t)}});
        end
        for (int t = 0; t < 6; t++) begin
            send(op_load, 22'h00b00 + 22'(t), 6'd5, 4'h0, 64'h0);
        end

        // random mix over a few tags and sets
        for (int n = 0; n < rand_reqs; n++) begin
            op_sel = 2'(rand_bits(2));
            op     = (op_sel == 2'd0) ? op_load : (op_sel == 2'd2) ? op_store : op_fill;
            tag    = 22'h00c00 + 22'(rand_bits(2));
            set    = {2'(rand_bits(2)), 4'b0001};
            off    = 4'(rand_bits(4));
            send(op, tag, set, off, rand_bits(64));
            // occasional idle cycle
            if (rand_bits(2) == 64'd0) begin
                step();
            end
        end

        // bounded wait for the last responses
        for (int i = 0; i < 20 && received < sent; i++) begin
            step();
        end
        // quiet cycles catch a stray response
        repeat (4) step();
        if (exp_q.size() != 0 || received != sent) begin
            $display("%0d requests sent but %0d responses received", sent, received);
            proto_errs++;
        end
        if (credits != queue_depth) begin
            $display("only %0d credits back after the last response", credits);
            proto_errs++;
        end

        $display("errors: value %0d, order %0d, protocol %0d",
                 value_errs, order_errs, proto_errs);
        if (value_errs + order_errs + proto_errs == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cache_top.f ====
hdl/cache_pkg.sv
hdl/req_queue.sv
hdl/tag_array.sv
hdl/data_array.sv
hdl/victim_select.sv
hdl/cache_top.sv
sim/cache_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the cache testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module cache_tb -f cache_top.f -o cache_sim \
    && ./obj_dir/cache_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
